// ==== psm_pkg.sv ====
/* Shared sizes, latencies, state encoding, status codes and control structs
   of the shift-and-scan sequencer. Imported by every module of the design. */

package psm_pkg;

    // ----------------------------------------
    // Array sizes and latencies
    // ----------------------------------------
    localparam int IDX_W       = 8;    // Context index width
    localparam int PARAMS_W    = 2;    // Inactive-column count width
    localparam int SCAN_LEN    = 3;    // Scan-chain shifts per context
    localparam int RD_LAT      = 3;    // Read data latency
    localparam int WR_LAT      = 1;    // Write data latency
    localparam int WRITE_EXTRA = 3;    // Extra contexts to drain the writes

    // Cycle counter covers both latencies and the post-read shift
    localparam int LAT_MAX = (RD_LAT > WR_LAT) ? RD_LAT : WR_LAT;
    localparam int CYC_MAX = (LAT_MAX > (2**PARAMS_W - 1)) ? LAT_MAX : (2**PARAMS_W - 1);
    localparam int CYC_W   = $clog2(CYC_MAX + 1);
    localparam int SCAN_W  = $clog2(SCAN_LEN + 1);

    // ----------------------------------------
    // Sequencer states
    // ----------------------------------------
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_PREREAD_SHIFT,
        ST_RD_CNT_START,
        ST_READING,
        ST_READING_LAT_WAIT,
        ST_POSTREAD_SHIFT,
        ST_PREWRITE_SHIFT,
        ST_WR_CNT_START,
        ST_WRITING,
        ST_WREN_HOLD_LAST,
        ST_WRITING_LAT_WAIT,
        ST_FINISH
    } seq_state_t;

    // Status code reported for each state
    typedef logic [4:0] status_code_t;

    localparam status_code_t STATUS_IDLE           = 5'd0;
    localparam status_code_t STATUS_PREREAD_SHIFT  = 5'd1;
    localparam status_code_t STATUS_RD_CNT_START   = 5'd2;
    localparam status_code_t STATUS_READING        = 5'd3;
    localparam status_code_t STATUS_RD_LAT_WAIT    = 5'd4;
    localparam status_code_t STATUS_POSTREAD_SHIFT = 5'd5;
    localparam status_code_t STATUS_PREWRITE_SHIFT = 5'd6;
    localparam status_code_t STATUS_WR_CNT_START   = 5'd7;
    localparam status_code_t STATUS_WRITING        = 5'd8;
    localparam status_code_t STATUS_WREN_HOLD      = 5'd9;
    localparam status_code_t STATUS_WR_LAT_WAIT    = 5'd10;
    localparam status_code_t STATUS_FINISH         = 5'd11;
    localparam status_code_t STATUS_BAD            = 5'd31;

    // ----------------------------------------
    // Control groups
    // ----------------------------------------
    // External address counters
    typedef struct packed {
        logic en;
        logic clear;
        logic wr_flag;      // 1 for a write sweep, 0 for a read sweep
        logic start;        // First address of the current context
    } cnt_ctrl_t;

    // Read and write data feeders
    typedef struct packed {
        logic rd_en;
        logic rd_clear;
        logic wr_en;
        logic wr_clear;
    } feeder_ctrl_t;

    // SRAM port, scan chain and output buffer
    typedef struct packed {
        logic sram_wren;
        logic sram_rden;
        logic cscan_en;
        logic buff_shift;
    } array_ctrl_t;

    typedef struct packed {
        status_code_t code;
        logic         shift_done;   // Array loaded, compute may start
        logic         done;         // One-cycle end of context
        logic         finalwrite;   // All outputs but the last are written
    } seq_status_t;

    // Internal latency and scan counter control
    typedef struct packed {
        logic cyc_en;
        logic cyc_clear;
        logic scan_en;
        logic scan_clear;
    } timer_ctrl_t;

endpackage

// ==== psm_ctx_tracker.sv ====
/* Context counter of the sequencer with the final-write, completion and
   output-buffer clear flags derived from it. */

`timescale 1ns/1ps

module psm_ctx_tracker
    import psm_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rstn,
    input  logic             i_fsm_reset,    // Restart the context count
    input  logic             i_ctx_inc,      // One context finished
    input  logic [IDX_W-1:0] i_ncontexts,
    input  logic             i_preload_en,
    input  logic             i_idle,         // Sequencer sits in IDLE
    output logic [IDX_W-1:0] o_ctx_cnt,
    output logic             o_finalwrite,
    output logic             o_completion,
    output logic             o_buff_clear
);

    // ----------------------------------------
    // Finished-context counter
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_ctx_cnt <= '0;
        end else if (i_fsm_reset) begin
            o_ctx_cnt <= '0;
        end else if (i_ctx_inc) begin
            o_ctx_cnt <= o_ctx_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // Flags
    // ----------------------------------------
    // Writes lag the reads by WRITE_EXTRA contexts,
    // so the last write runs at ncontexts+WRITE_EXTRA-1
    assign o_finalwrite = (o_ctx_cnt == i_ncontexts + IDX_W'(WRITE_EXTRA - 1));

    // Everything written, start pulses are ignored until i_fsm_reset
    assign o_completion = (o_ctx_cnt == i_ncontexts + IDX_W'(WRITE_EXTRA));

    // Buffer starts clean when nothing is preloaded into it
    assign o_buff_clear = i_idle && (!i_preload_en || (o_ctx_cnt > i_ncontexts));

endmodule

// ==== psm_phase_timer.sv ====
/* Latency cycle counter and stall-aware scan counter of the sequencer.
   Both are steered by the decoder through one timer control struct. */

`timescale 1ns/1ps

module psm_phase_timer
    import psm_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rstn,
    input  timer_ctrl_t       i_tctrl,
    input  logic              i_pipeline_en,   // Low stalls the scan chain
    output logic [CYC_W-1:0]  o_cyc_cnt,
    output logic [SCAN_W-1:0] o_scan_cnt
);

    // ----------------------------------------
    // Latency and post-read shift counter
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_cyc_cnt <= '0;
        end else if (i_tctrl.cyc_clear) begin
            o_cyc_cnt <= '0;
        end else if (i_tctrl.cyc_en) begin
            o_cyc_cnt <= o_cyc_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // Scan shift counter
    // ----------------------------------------
    // Counts only cycles in which the chain really moves.
    // Wraps after the last shift as the phase ends on that same edge
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_scan_cnt <= '0;
        end else if (i_tctrl.scan_clear) begin
            o_scan_cnt <= '0;
        end else if (i_tctrl.scan_en && i_pipeline_en) begin
            if (o_scan_cnt == SCAN_W'(SCAN_LEN - 1)) begin
                o_scan_cnt <= '0;
            end else begin
                o_scan_cnt <= o_scan_cnt + 1'b1;
            end
        end
    end

    // Pre-shift phase ends on the wrap, so the next one starts from zero
    a_scan_idle_zero: assert property (@(posedge i_clk) disable iff (!i_rstn)
        !i_tctrl.scan_en |-> (o_scan_cnt == '0));

endmodule

// ==== psm_shift_fsm.sv ====
/* State register and next-state logic of the shift-and-scan sequencer.
   Picks the read, shift-read or shift-write path for each start pulse. */

`timescale 1ns/1ps

module psm_shift_fsm
    import psm_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rstn,
    input  logic                i_fsm_start,
    input  logic                i_done,          // Address sweep finished
    input  logic                i_pipeline_en,
    input  logic                i_preload_en,
    input  logic [IDX_W-1:0]    i_ncontexts,
    input  logic [PARAMS_W-1:0] i_inactive_cols,
    input  logic [IDX_W-1:0]    i_ctx_cnt,
    input  logic                i_completion,
    input  logic [CYC_W-1:0]    i_cyc_cnt,
    input  logic [SCAN_W-1:0]   i_scan_cnt,
    output seq_state_t          o_state
);

    seq_state_t state_d;
    logic       scan_last;

    // Last real shift of a pre-shift phase
    assign scan_last = i_pipeline_en && (i_scan_cnt == SCAN_W'(SCAN_LEN - 1));

    // ----------------------------------------
    // State register
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_state <= ST_IDLE;
        end else begin
            o_state <= state_d;
        end
    end

    // ----------------------------------------
    // Transitions
    // ----------------------------------------
    always_comb begin
        state_d = o_state;
        case (o_state)
            ST_IDLE: begin
                // Start is dropped once every context is written
                if (i_fsm_start && !i_completion) begin
                    if (i_ctx_cnt >= IDX_W'(WRITE_EXTRA)) begin
                        // Write pipeline full, shift out and write
                        state_d = ST_PREWRITE_SHIFT;
                    end else if (!i_preload_en || (i_ctx_cnt > i_ncontexts)) begin
                        // Nothing to load for this context
                        state_d = ST_FINISH;
                    end else if (i_ctx_cnt == '0) begin
                        // Empty array, read without shifting
                        state_d = ST_RD_CNT_START;
                    end else begin
                        state_d = ST_PREREAD_SHIFT;
                    end
                end
            end
            ST_PREREAD_SHIFT: begin
                // Final shift only pushes the last read in
                if (scan_last) begin
                    state_d = (i_ctx_cnt == i_ncontexts) ? ST_FINISH : ST_RD_CNT_START;
                end
            end
            ST_RD_CNT_START: begin
                state_d = ST_READING;
            end
            ST_READING: begin
                if (i_done) begin
                    state_d = ST_READING_LAT_WAIT;
                end
            end
            ST_READING_LAT_WAIT: begin
                // Underused array needs extra buffer shifts
                if (i_cyc_cnt == CYC_W'(RD_LAT)) begin
                    state_d = (i_inactive_cols != '0) ? ST_POSTREAD_SHIFT : ST_FINISH;
                end
            end
            ST_POSTREAD_SHIFT: begin
                if (i_cyc_cnt == CYC_W'(i_inactive_cols - 1'b1)) begin
                    state_d = ST_FINISH;
                end
            end
            ST_PREWRITE_SHIFT: begin
                if (scan_last) begin
                    state_d = ST_WR_CNT_START;
                end
            end
            ST_WR_CNT_START: begin
                state_d = ST_WRITING;
            end
            ST_WRITING: begin
                if (i_done) begin
                    state_d = ST_WREN_HOLD_LAST;
                end
            end
            // Extra wren cycle for the last address
            ST_WREN_HOLD_LAST: begin
                state_d = ST_WRITING_LAT_WAIT;
            end
            ST_WRITING_LAT_WAIT: begin
                // Read again while there is still input to load
                if (i_cyc_cnt == CYC_W'(WR_LAT)) begin
                    if (i_preload_en && (i_ctx_cnt < i_ncontexts)) begin
                        state_d = ST_RD_CNT_START;
                    end else begin
                        state_d = ST_FINISH;
                    end
                end
            end
            ST_FINISH: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // Completion is only reached on the way back to IDLE and holds it there
    a_idle_on_completion: assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_completion |-> (o_state == ST_IDLE));

endmodule

// ==== psm_ctrl_decoder.sv ====
/* Output decoder of the sequencer: turns the current state into the control
   groups for counters, feeders, array and timer, plus the status code. */

`timescale 1ns/1ps

module psm_ctrl_decoder
    import psm_pkg::*;
(
    input  seq_state_t       i_state,
    input  logic             i_done,
    input  logic [CYC_W-1:0] i_cyc_cnt,
    input  logic             i_fsm_reset,
    output cnt_ctrl_t        o_cnt,
    output feeder_ctrl_t     o_feeder,
    output array_ctrl_t      o_array,
    output status_code_t     o_status_code,
    output logic             o_shift_done,
    output logic             o_done,
    output timer_ctrl_t      o_tctrl,
    output logic             o_ctx_inc
);

    always_comb begin
        // ----------------------------------------
        // Safe defaults, all quiet
        // ----------------------------------------
        o_cnt         = '{en: 1'b0, clear: i_fsm_reset, wr_flag: 1'b0, start: 1'b0};
        o_feeder      = '{rd_en: 1'b0, rd_clear: 1'b1, wr_en: 1'b0, wr_clear: 1'b1};
        o_array       = '0;
        o_tctrl       = '{cyc_en: 1'b0, cyc_clear: 1'b1, scan_en: 1'b0, scan_clear: 1'b1};
        o_status_code = STATUS_BAD;
        o_shift_done  = 1'b0;
        o_done        = 1'b0;
        o_ctx_inc     = 1'b0;

        case (i_state)
            ST_IDLE: begin
                o_status_code = STATUS_IDLE;
            end
            ST_PREREAD_SHIFT: begin
                // Chain moves, scan counter tracks it
                o_array.cscan_en   = 1'b1;
                o_tctrl.scan_en    = 1'b1;
                o_tctrl.scan_clear = 1'b0;
                o_status_code      = STATUS_PREREAD_SHIFT;
            end
            ST_RD_CNT_START, ST_READING: begin
                o_cnt.en           = 1'b1;
                o_cnt.start        = (i_state == ST_RD_CNT_START);
                o_feeder.rd_en     = 1'b1;
                o_feeder.rd_clear  = 1'b0;
                o_array.sram_rden  = 1'b1;
                o_shift_done       = 1'b1;
                o_status_code      = (i_state == ST_RD_CNT_START) ? STATUS_RD_CNT_START
                                                                  : STATUS_READING;
            end
            ST_READING_LAT_WAIT: begin
                // Feeder keeps its data while the last reads land
                o_feeder.rd_clear  = 1'b0;
                o_shift_done       = 1'b1;
                o_tctrl.cyc_en     = 1'b1;
                // Restart from zero for the post-read shift
                o_tctrl.cyc_clear  = (i_cyc_cnt == CYC_W'(RD_LAT));
                o_status_code      = STATUS_RD_LAT_WAIT;
            end
            ST_POSTREAD_SHIFT: begin
                o_array.buff_shift = 1'b1;
                o_tctrl.cyc_en     = 1'b1;
                o_tctrl.cyc_clear  = 1'b0;
                o_status_code      = STATUS_POSTREAD_SHIFT;
            end
            ST_PREWRITE_SHIFT: begin
                o_array.cscan_en   = 1'b1;
                o_tctrl.scan_en    = 1'b1;
                o_tctrl.scan_clear = 1'b0;
                o_status_code      = STATUS_PREWRITE_SHIFT;
            end
            ST_WR_CNT_START: begin
                o_cnt              = '{en: 1'b1, clear: i_fsm_reset, wr_flag: 1'b1, start: 1'b1};
                o_feeder.wr_en     = 1'b1;
                o_feeder.wr_clear  = 1'b0;
                o_shift_done       = 1'b1;
                o_status_code      = STATUS_WR_CNT_START;
            end
            ST_WRITING: begin
                // Write stops on the cycle the sweep ends
                o_cnt.en           = 1'b1;
                o_cnt.wr_flag      = 1'b1;
                o_feeder.wr_en     = !i_done;
                o_feeder.wr_clear  = 1'b0;
                o_array.sram_wren  = !i_done;
                o_shift_done       = 1'b1;
                o_status_code      = STATUS_WRITING;
            end
            ST_WREN_HOLD_LAST: begin
                o_cnt.wr_flag      = 1'b1;
                o_feeder.wr_en     = 1'b1;
                o_feeder.wr_clear  = 1'b0;
                o_array.sram_wren  = 1'b1;
                o_shift_done       = 1'b1;
                o_status_code      = STATUS_WREN_HOLD;
            end
            ST_WRITING_LAT_WAIT: begin
                o_cnt.wr_flag      = 1'b1;
                o_feeder.wr_en     = 1'b1;
                o_feeder.wr_clear  = 1'b0;
                o_shift_done       = 1'b1;
                o_tctrl.cyc_en     = 1'b1;
                o_tctrl.cyc_clear  = 1'b0;
                o_status_code      = STATUS_WR_LAT_WAIT;
            end
            ST_FINISH: begin
                // Context is closed here
                o_shift_done       = 1'b1;
                o_done             = 1'b1;
                o_ctx_inc          = 1'b1;
                o_status_code      = STATUS_FINISH;
            end
            default: begin
                o_status_code = STATUS_BAD;
            end
        endcase
    end

endmodule

// ==== psm_shift_sequencer.sv ====
/* Top level of the shift-and-scan sequencer. Connects the context tracker,
   phase timer, FSM and output decoder, and packs the status word. */

`timescale 1ns/1ps

module psm_shift_sequencer
    import psm_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rstn,
    input  logic                i_fsm_start,
    input  logic                i_fsm_reset,
    input  logic [IDX_W-1:0]    i_ncontexts,
    input  logic                i_preload_en,
    input  logic [PARAMS_W-1:0] i_inactive_cols,
    input  logic                i_pipeline_en,
    input  logic                i_done,
    output cnt_ctrl_t           o_cnt,
    output feeder_ctrl_t        o_feeder,
    output array_ctrl_t         o_array,
    output seq_status_t         o_status,
    output logic                o_buff_clear    // Output buffer clear
);

    seq_state_t        state;
    timer_ctrl_t       tctrl;
    logic              ctx_inc;
    logic [CYC_W-1:0]  cyc_cnt;
    logic [SCAN_W-1:0] scan_cnt;
    logic [IDX_W-1:0]  ctx_cnt;
    logic              completion;
    logic              finalwrite;
    status_code_t      status_code;
    logic              shift_done;
    logic              done;

    // ----------------------------------------
    // Context tracking and timing
    // ----------------------------------------
    psm_ctx_tracker u_tracker (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .i_fsm_reset  (i_fsm_reset),
        .i_ctx_inc    (ctx_inc),
        .i_ncontexts  (i_ncontexts),
        .i_preload_en (i_preload_en),
        .i_idle       (state == ST_IDLE),
        .o_ctx_cnt    (ctx_cnt),
        .o_finalwrite (finalwrite),
        .o_completion (completion),
        .o_buff_clear (o_buff_clear)
    );

    psm_phase_timer u_timer (
        .i_clk         (i_clk),
        .i_rstn        (i_rstn),
        .i_tctrl       (tctrl),
        .i_pipeline_en (i_pipeline_en),
        .o_cyc_cnt     (cyc_cnt),
        .o_scan_cnt    (scan_cnt)
    );

    // ----------------------------------------
    // Sequencer FSM and its output decode
    // ----------------------------------------
    psm_shift_fsm u_fsm (
        .i_clk           (i_clk),
        .i_rstn          (i_rstn),
        .i_fsm_start     (i_fsm_start),
        .i_done          (i_done),
        .i_pipeline_en   (i_pipeline_en),
        .i_preload_en    (i_preload_en),
        .i_ncontexts     (i_ncontexts),
        .i_inactive_cols (i_inactive_cols),
        .i_ctx_cnt       (ctx_cnt),
        .i_completion    (completion),
        .i_cyc_cnt       (cyc_cnt),
        .i_scan_cnt      (scan_cnt),
        .o_state         (state)
    );

    psm_ctrl_decoder u_decoder (
        .i_state       (state),
        .i_done        (i_done),
        .i_cyc_cnt     (cyc_cnt),
        .i_fsm_reset   (i_fsm_reset),
        .o_cnt         (o_cnt),
        .o_feeder      (o_feeder),
        .o_array       (o_array),
        .o_status_code (status_code),
        .o_shift_done  (shift_done),
        .o_done        (done),
        .o_tctrl       (tctrl),
        .o_ctx_inc     (ctx_inc)
    );

    assign o_status = '{code: status_code, shift_done: shift_done, done: done,
                        finalwrite: finalwrite};

    // SRAM port is single ported
    a_rw_excl: assert property (@(posedge i_clk) disable iff (!i_rstn)
        !(o_array.sram_wren && o_array.sram_rden));

    // FINISH always falls back to IDLE, so done is a single pulse
    a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_status.done |=> !o_status.done);

endmodule

// ==== tb_clk_gen.sv ====
/* Testbench clock and reset source. 10 ns clock, active-low reset held
   for 16 cycles and released on a falling edge. */

`timescale 1ns/1ps

module tb_clk_gen (
    output logic o_clk,
    output logic o_rstn
);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    // Release away from the rising edge
    initial begin
        o_rstn = 1'b0;
        repeat (16) @(posedge o_clk);
        @(negedge o_clk);
        o_rstn = 1'b1;
    end

endmodule

// ==== tb_psm_shift_sequencer.sv ====
/* Table-driven testbench of the shift-and-scan sequencer. Models the external
   address counters, runs one context per table row and checks cycle counts. */

`timescale 1ns/1ps

module tb_psm_shift_sequencer
    import psm_pkg::*;
;

    // Expected path of one start pulse
    localparam logic [2:0] P_READ   = 3'd0;   // Plain read
    localparam logic [2:0] P_SREAD  = 3'd1;   // Shift then read
    localparam logic [2:0] P_SONLY  = 3'd2;   // Last shift, no read
    localparam logic [2:0] P_WRITE  = 3'd3;   // Shift then write
    localparam logic [2:0] P_WREAD  = 3'd4;   // Shift, write, read
    localparam logic [2:0] P_FINISH = 3'd5;   // Immediate finish
    localparam logic [2:0] P_NONE   = 3'd6;   // Start ignored
    localparam int         NROWS    = 12;
    localparam int         TIMEOUT  = 200;

    typedef struct packed {
        logic             rst_before;
        logic [IDX_W-1:0] nctx;
        logic             preload;
        logic [1:0]       inact;
        logic [7:0]       stall;
        logic [2:0]       path;
    } row_t;

    logic                clk;
    logic                rstn;
    logic                fsm_start;
    logic                fsm_reset;
    logic [IDX_W-1:0]    ncontexts;
    logic                preload_en;
    logic [PARAMS_W-1:0] inactive_cols;
    logic                pipeline_en;
    logic                sweep_done;
    cnt_ctrl_t           cnt;
    feeder_ctrl_t        feeder;
    array_ctrl_t         arr;
    seq_status_t         status;
    logic                buff_clear;

    row_t   table_rows [NROWS];
    integer seed;
    int     errors;
    int     rows_failed;
    int     ctx_model;

    tb_clk_gen u_clk (
        .o_clk  (clk),
        .o_rstn (rstn)
    );

    psm_shift_sequencer DUT (
        .i_clk           (clk),
        .i_rstn          (rstn),
        .i_fsm_start     (fsm_start),
        .i_fsm_reset     (fsm_reset),
        .i_ncontexts     (ncontexts),
        .i_preload_en    (preload_en),
        .i_inactive_cols (inactive_cols),
        .i_pipeline_en   (pipeline_en),
        .i_done          (sweep_done),
        .o_cnt           (cnt),
        .o_feeder        (feeder),
        .o_array         (arr),
        .o_status        (status),
        .o_buff_clear    (buff_clear)
    );

    task automatic report_mismatch(input string what, input int got, input int exp);
        $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        errors++;
    endtask

    // Pre-shift length in cycles, the phase ends on the last enabled shift
    function automatic int shift_cycles(input logic [7:0] stall);
        int ones;
        int n;
        ones = 0;
        n = 0;
        while (ones < SCAN_LEN && n < TIMEOUT) begin
            ones += stall[n % 8];
            n++;
        end
        return n;
    endfunction

    // ----------------------------------------
    // One start pulse, sampled on falling edges
    // ----------------------------------------
    task automatic run_row(input int idx);
        row_t r;
        int   codes [32];
        int   rden_n, wren_n, cscan_n, bshift_n, start_n, scan_hi;
        int   rem, len, rd_len, wr_len, k, err0;
        bit   got_done, do_shift, do_read, do_write, in_shift;
        r = table_rows[idx];
        err0 = errors;
        foreach (codes[i]) codes[i] = 0;
        rden_n = 0;
        wren_n = 0;
        cscan_n = 0;
        bshift_n = 0;
        start_n = 0;
        scan_hi = 0;
        rem = 0;
        rd_len = 0;
        wr_len = 0;
        got_done = 0;

        // Settle the run settings, optional context reset
        ncontexts = r.nctx;
        preload_en = r.preload;
        inactive_cols = r.inact;
        fsm_reset = r.rst_before;
        @(negedge clk);
        if (r.rst_before && !cnt.clear) report_mismatch("cnt.clear in reset", 0, 1);
        fsm_reset = 1'b0;
        if (r.rst_before) ctx_model = 0;
        @(negedge clk);
        if (status.finalwrite != (ctx_model == r.nctx + 2))
            report_mismatch("finalwrite", status.finalwrite, ctx_model == r.nctx + 2);
        if (buff_clear != (!r.preload || ctx_model > r.nctx))
            report_mismatch("buff_clear", buff_clear, !r.preload || ctx_model > r.nctx);
        fsm_start = 1'b1;

        k = 0;
        while (!got_done && k < TIMEOUT) begin
            @(negedge clk);
            fsm_start = 1'b0;
            codes[status.code]++;
            rden_n += arr.sram_rden;
            cscan_n += arr.cscan_en;
            bshift_n += arr.buff_shift;
            start_n += cnt.start;
            in_shift = (status.code == STATUS_PREREAD_SHIFT)
                       || (status.code == STATUS_PREWRITE_SHIFT);
            // Array is not loaded while the chain moves
            if (arr.cscan_en && status.shift_done)
                report_mismatch("shift_done while scanning", 1, 0);
            if ((cnt.start || status.done) && !status.shift_done)
                report_mismatch("shift_done with start or done", 0, 1);
            got_done = status.done;
            // External counter model
            sweep_done = 1'b0;
            if (cnt.start) begin
                len = ($random(seed) & 3) + 1;
                rem = len;
                if (cnt.wr_flag) wr_len = len;
                else rd_len = len;
            end else if (rem > 0) begin
                rem--;
                if (rem == 0) sweep_done = 1'b1;
            end
            pipeline_en = r.stall[k % 8];
            // Stall value seen by the coming rising edge
            if (in_shift && pipeline_en)
                scan_hi++;
            // Wren follows the sweep end driven just above
            #1;
            wren_n += arr.sram_wren;
            k++;
        end
        pipeline_en = 1'b1;
        sweep_done = 1'b0;

        if (r.path == P_NONE) begin
            if (got_done) $display("start accepted after completion at %0t", $time);
            if (got_done) errors++;
            if (codes[STATUS_IDLE] != k) report_mismatch("idle cycles", codes[0], k);
        end else if (!got_done) begin
            $display("timeout: no done for row %0d within %0d cycles", idx, TIMEOUT);
            errors++;
        end else begin
            do_shift = r.path inside {P_SREAD, P_SONLY, P_WRITE, P_WREAD};
            do_read = r.path inside {P_READ, P_SREAD, P_WREAD};
            do_write = r.path inside {P_WRITE, P_WREAD};
            if (scan_hi != (do_shift ? SCAN_LEN : 0))
                report_mismatch("enabled shift cycles", scan_hi, do_shift ? SCAN_LEN : 0);
            if (cscan_n != (do_shift ? shift_cycles(r.stall) : 0))
                report_mismatch("cscan_en cycles", cscan_n,
                                do_shift ? shift_cycles(r.stall) : 0);
            if (start_n != int'(do_read) + int'(do_write))
                report_mismatch("cnt.start pulses", start_n, int'(do_read) + int'(do_write));
            if (codes[STATUS_READING] != (do_read ? rd_len : 0))
                report_mismatch("reading cycles", codes[3], do_read ? rd_len : 0);
            if (rden_n != (do_read ? rd_len + 1 : 0))
                report_mismatch("rden cycles", rden_n, do_read ? rd_len + 1 : 0);
            if (codes[STATUS_RD_LAT_WAIT] != (do_read ? RD_LAT + 1 : 0))
                report_mismatch("read latency cycles", codes[4], do_read ? RD_LAT + 1 : 0);
            if (bshift_n != (do_read ? int'(r.inact) : 0))
                report_mismatch("buff_shift cycles", bshift_n, do_read ? r.inact : 0);
            if (codes[STATUS_WRITING] != (do_write ? wr_len : 0))
                report_mismatch("writing cycles", codes[8], do_write ? wr_len : 0);
            // Sweep cycles before the end plus the hold cycle
            if (wren_n != (do_write ? wr_len : 0))
                report_mismatch("wren cycles", wren_n, do_write ? wr_len : 0);
            if (codes[STATUS_WR_LAT_WAIT] != (do_write ? WR_LAT + 1 : 0))
                report_mismatch("write latency cycles", codes[10], do_write ? WR_LAT + 1 : 0);
            if (codes[STATUS_FINISH] != 1) report_mismatch("done cycles", codes[11], 1);
            // Done is a single pulse, back in IDLE right after
            @(negedge clk);
            if (status.done) report_mismatch("done after pulse", 1, 0);
            if (status.code != STATUS_IDLE) report_mismatch("code after done", status.code, 0);
            ctx_model++;
        end

        if (errors != err0) rows_failed++;
        $display("row %0d path %0d ctx %0d: %s", idx, r.path, ctx_model,
                 (errors == err0) ? "ok" : "failed");
    endtask

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------
    initial begin
        table_rows[0]  = '{1'b0, 8'd2, 1'b1, 2'd2, 8'hFF,        P_READ};
        table_rows[1]  = '{1'b0, 8'd2, 1'b1, 2'd0, 8'b1011_0110, P_SREAD};
        table_rows[2]  = '{1'b0, 8'd2, 1'b1, 2'd1, 8'hFF,        P_SONLY};
        table_rows[3]  = '{1'b0, 8'd2, 1'b1, 2'd0, 8'b0110_1101, P_WRITE};
        table_rows[4]  = '{1'b0, 8'd2, 1'b1, 2'd0, 8'hFF,        P_WRITE};
        table_rows[5]  = '{1'b0, 8'd2, 1'b1, 2'd0, 8'hFF,        P_NONE};
        table_rows[6]  = '{1'b1, 8'd4, 1'b1, 2'd3, 8'hFF,        P_READ};
        table_rows[7]  = '{1'b0, 8'd4, 1'b1, 2'd0, 8'b1100_1011, P_SREAD};
        table_rows[8]  = '{1'b0, 8'd4, 1'b1, 2'd1, 8'hFF,        P_SREAD};
        table_rows[9]  = '{1'b0, 8'd4, 1'b1, 2'd2, 8'b1110_1110, P_WREAD};
        table_rows[10] = '{1'b0, 8'd4, 1'b0, 2'd0, 8'hFF,        P_WRITE};
        table_rows[11] = '{1'b1, 8'd4, 1'b0, 2'd0, 8'hFF,        P_FINISH};
    end

    initial begin
        int k;
        fsm_start = 1'b0;
        fsm_reset = 1'b0;
        ncontexts = '0;
        preload_en = 1'b0;
        inactive_cols = '0;
        pipeline_en = 1'b1;
        sweep_done = 1'b0;
        seed = 79290;
        errors = 0;
        rows_failed = 0;
        ctx_model = 0;

        k = 0;
        while (!rstn && k < 100) begin
            @(negedge clk);
            k++;
        end
        if (!rstn) begin
            $display("reset never released");
            errors++;
        end
        @(negedge clk);
        // Reset state of every output group
        if (arr != '0) report_mismatch("array enables", arr, 0);
        if (cnt != '0) report_mismatch("counter controls", cnt, 0);
        if (feeder != 4'b0101) report_mismatch("feeder controls", feeder, 4'b0101);
        if (status.code != STATUS_IDLE) report_mismatch("status code", status.code, 0);
        if (status.done) report_mismatch("done", 1, 0);
        if (status.shift_done) report_mismatch("shift_done", 1, 0);
        $display("reset state: %s", (errors == 0) ? "ok" : "failed");

        for (int i = 0; i < NROWS; i++) begin
            run_row(i);
        end

        $display("rows %0d, failed %0d, errors %0d", NROWS, rows_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== psm_shift_sequencer.f ====
psm_pkg.sv
psm_ctx_tracker.sv
psm_phase_timer.sv
psm_shift_fsm.sv
psm_ctrl_decoder.sv
psm_shift_sequencer.sv
tb_clk_gen.sv
tb_psm_shift_sequencer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_psm_shift_sequencer \
    -f psm_shift_sequencer.f -o sim_psm > build.log 2>&1 \
    && ./obj_dir/sim_psm > sim.log 2>&1 \
    || { echo "build or run error, see build.log and sim.log"; exit 1; }
grep -q "Simulation finished: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
